//--- hazardPkg.sv
package hazardPkg;

    localparam int RegAddrW  = 5;
    localparam int MduCountW = 4;

    // Register number as decoded from the rs, rt and rd fields
    typedef logic [RegAddrW-1:0] regAddrT;

    typedef logic [MduCountW-1:0] mduCountT; // Busy cycles still ahead of the MDU

    // Register zero always reads as zero and is never written
    localparam regAddrT RegZero = '0;

    typedef enum logic [1:0] {
        FwdNone = 2'b00,  // Value read in ID or carried down the pipe
        FwdMem  = 2'b01,  // Result held in the EX/MEM register
        FwdWb   = 2'b10   // Result on its way into the register file
    } fwdSelT;

    // Operation handed to the MDU by the instruction in EX
    typedef enum logic [1:0] {
        MduNone = 2'b00,
        MduMult = 2'b01,
        MduDiv  = 2'b10
    } mduOpT;

    // The count loaded at issue equals the number of cycles the unit stays busy
    localparam mduCountT MultCycles = mduCountT'(5);
    localparam mduCountT DivCycles  = mduCountT'(10);

endpackage

//--- regTrackIf.sv
`timescale 1ns/1ps

interface regTrackIf
    import hazardPkg::*;
();

    regAddrT rsD;     // Sources of the instruction in decode
    regAddrT rtD;
    regAddrT rsE;     // Sources of the instruction in execute
    regAddrT rtE;

    regAddrT destE;   // Destinations further down the pipe
    regAddrT destM;
    regAddrT destW;

    logic    writeM;
    logic    writeW;
    logic    loadE;   // EX holds a load whose data only appears in MEM

    // Bypass selection looks at every stage
    modport fwd (
        input rsD, rtD, rsE, rtE,
        input destE, destM, destW,
        input writeM, writeW, loadE
    );

    modport hazard (
        input rsD, rtD,
        input destE, loadE
    );

endinterface

//--- forwardSelect.sv
`timescale 1ns/1ps

module forwardSelect
    import hazardPkg::*;
(
    regTrackIf.fwd regs,
    output fwdSelT fwdAD,
    output fwdSelT fwdBD,
    output fwdSelT fwdAE,
    output fwdSelT fwdBE
);

    // The younger result in MEM wins over the older one in WB
    function automatic fwdSelT pickSource(
        input regAddrT src,
        input regAddrT dstM,
        input logic    wrM,
        input regAddrT dstW,
        input logic    wrW
    );
        fwdSelT sel;
        if (src == RegZero) begin
            sel = FwdNone;
        end else if (wrM && (src == dstM)) begin
            sel = FwdMem;
        end else if (wrW && (src == dstW)) begin
            sel = FwdWb;
        end else begin
            sel = FwdNone;
        end
        return sel;
    endfunction

    // Decode operands feed the branch comparator
    always_comb begin
        fwdAD = pickSource(regs.rsD, regs.destM, regs.writeM, regs.destW, regs.writeW);
        fwdBD = pickSource(regs.rtD, regs.destM, regs.writeM, regs.destW, regs.writeW);
    end

    always_comb begin
        fwdAE = pickSource(regs.rsE, regs.destM, regs.writeM, regs.destW, regs.writeW);
        fwdBE = pickSource(regs.rtE, regs.destM, regs.writeM, regs.destW, regs.writeW);
    end

endmodule

//--- stallDetect.sv
`timescale 1ns/1ps

module stallDetect
    import hazardPkg::*;
(
    input  logic      clk,
    input  logic      rstN,
    regTrackIf.hazard regs,
    input  mduOpT     mduOpE,
    input  logic      mduUseD,
    output logic      loadStall,
    output logic      mduStall,
    output logic      mduBusy
);

    mduCountT mduCount;
    mduCountT mduCountNext;
    logic     destHitD;
    logic     loadDestValid;

    // Load data arrives at the end of MEM, one cycle too late for a reader in ID
    assign destHitD      = (regs.destE == regs.rsD) || (regs.destE == regs.rtD);
    assign loadDestValid = regs.loadE && (regs.destE != RegZero);
    assign loadStall     = loadDestValid && destHitD;

    // A new operation restarts the count, otherwise it runs down to zero
    always_comb begin
        case (mduOpE)
            MduMult: begin
                mduCountNext = MultCycles;
            end
            MduDiv: begin
                mduCountNext = DivCycles;
            end
            default: begin
                if (mduCount != '0) begin
                    mduCountNext = mduCount - mduCountT'(1);
                end else begin
                    mduCountNext = mduCount;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mduCount <= '0;
        end else begin
            mduCount <= mduCountNext;
        end
    end

    // Busy from the cycle after issue for exactly the loaded number of cycles
    assign mduBusy = (mduCount != '0);

    // HI/LO access or a second MDU operation has to wait for the unit
    assign mduStall = mduBusy && mduUseD;

endmodule

//--- pipeControl.sv
`timescale 1ns/1ps

module pipeControl (
    input  logic loadStall,
    input  logic mduStall,
    input  logic likelyD,
    input  logic branchTakenD,
    output logic stallPc,
    output logic stallIfId,
    output logic flushIfId,
    output logic flushIdEx
);

    logic holdFront;
    logic likelyAnnul;

    // Either hazard freezes the front end with the instruction kept in ID
    assign holdFront = loadStall || mduStall;

    assign stallPc   = holdFront;
    assign stallIfId = holdFront;

    // The held instruction must not also advance into EX
    assign flushIdEx = holdFront;

    // Delay slot of a branch-likely is annulled when the branch falls through
    assign likelyAnnul = likelyD && !branchTakenD;

    // While ID waits the branch has not been resolved yet
    assign flushIfId = likelyAnnul && !holdFront;

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import hazardPkg::*;
(
    input  logic    clk,
    input  logic    rstN,
    input  regAddrT rsD,
    input  regAddrT rtD,
    input  regAddrT rsE,
    input  regAddrT rtE,
    input  regAddrT destE,
    input  regAddrT destM,
    input  regAddrT destW,
    input  logic    writeM,
    input  logic    writeW,
    input  logic    loadE,
    input  logic    mduUseD,
    input  logic    likelyD,
    input  logic    branchTakenD,
    input  mduOpT   mduOpE,
    output fwdSelT  fwdAD,
    output fwdSelT  fwdBD,
    output fwdSelT  fwdAE,
    output fwdSelT  fwdBE,
    output logic    stallPc,
    output logic    stallIfId,
    output logic    flushIfId,
    output logic    flushIdEx,
    output logic    mduBusy
);

    logic loadStall;
    logic mduStall;

    regTrackIf regs ();

    // Stage register numbers shared by both detection parts
    assign regs.rsD    = rsD;
    assign regs.rtD    = rtD;
    assign regs.rsE    = rsE;
    assign regs.rtE    = rtE;
    assign regs.destE  = destE;
    assign regs.destM  = destM;
    assign regs.destW  = destW;
    assign regs.writeM = writeM;
    assign regs.writeW = writeW;
    assign regs.loadE  = loadE;

    forwardSelect fwdSel (
        .regs  (regs.fwd),
        .fwdAD (fwdAD),
        .fwdBD (fwdBD),
        .fwdAE (fwdAE),
        .fwdBE (fwdBE)
    );

    stallDetect stallDet (
        .clk       (clk),
        .rstN      (rstN),
        .regs      (regs.hazard),
        .mduOpE    (mduOpE),
        .mduUseD   (mduUseD),
        .loadStall (loadStall),
        .mduStall  (mduStall),
        .mduBusy   (mduBusy)
    );

    pipeControl pipeCtrl (
        .loadStall    (loadStall),
        .mduStall     (mduStall),
        .likelyD      (likelyD),
        .branchTakenD (branchTakenD),
        .stallPc      (stallPc),
        .stallIfId    (stallIfId),
        .flushIfId    (flushIfId),
        .flushIdEx    (flushIdEx)
    );

endmodule

//--- hazardUnit_properties.sv
`timescale 1ns/1ps

module hazardUnit_properties
    import hazardPkg::*;
(
    input logic  clk,
    input logic  rstN,
    input mduOpT mduOpE,
    input logic  mduBusy,
    input logic  stallIfId,
    input logic  flushIfId,
    input logic  flushIdEx
);

    // The countdown is cleared by the reset cycle itself
    busyClearAfterReset: assert property (
        @(posedge clk) !rstN |=> !mduBusy
    ) else $error("mduBusy high in the cycle after reset");

    // A stalled branch-likely is not resolved, so its delay slot stays
    noFlushWhileStalled: assert property (
        @(posedge clk) disable iff (!rstN) !(flushIfId && stallIfId)
    ) else $error("flushIfId and stallIfId high together");

    bubbleFollowsHold: assert property (
        @(posedge clk) disable iff (!rstN) flushIdEx == stallIfId
    ) else $error("flushIdEx differs from stallIfId");

    // The pipeline keeps MDU operations out of EX until the unit is free
    noIssueWhileBusy: assert property (
        @(posedge clk) disable iff (!rstN) mduBusy |-> (mduOpE == MduNone)
    ) else $error("MDU operation issued while the unit is busy");

endmodule

bind hazardUnit hazardUnit_properties i_props (
    .clk       (clk),
    .rstN      (rstN),
    .mduOpE    (mduOpE),
    .mduBusy   (mduBusy),
    .stallIfId (stallIfId),
    .flushIfId (flushIfId),
    .flushIdEx (flushIdEx)
);

//--- hazardUnitTb.sv
`timescale 1ns/1ps

module hazardUnitTb
    import hazardPkg::*;
();

    localparam int ClkHalf     = 2;
    localparam int ResetCycles = 3;
    localparam int FwdRounds   = 40;
    localparam int LoadRounds  = 16;
    localparam int TestCycles  = ResetCycles + 8 + FwdRounds + 4 + LoadRounds + 6
                               + 2 * (int'(MultCycles) + 2) + int'(DivCycles) + 4 + 8 + 8;
    localparam int MarginCycles = 50;
    localparam int TimeoutNs    = (TestCycles + MarginCycles) * 2 * ClkHalf;

    logic    clk;
    logic    rstN;
    regAddrT rsD, rtD, rsE, rtE;
    regAddrT destE, destM, destW;
    logic    writeM, writeW, loadE;
    logic    mduUseD, likelyD, branchTakenD;
    mduOpT   mduOpE;
    fwdSelT  fwdAD, fwdBD, fwdAE, fwdBE;
    logic    stallPc, stallIfId, flushIfId, flushIdEx, mduBusy;

    logic [15:0] lfsrState;
    string       testName;
    int          checkCount;
    int          errorCount;
    int          errorsAtStart;

    hazardUnit i_dut (.*);

    always #ClkHalf clk = ~clk;

    // Galois LFSR, one step for every bit handed out
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? ({1'b0, lfsrState[15:1]} ^ 16'hB400)
                                     : {1'b0, lfsrState[15:1]};
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("CHECK FAILED test %s, %s: expected %0d actual %0d",
                     testName, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        testName      = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        $display("Test %s done with %0d errors", testName, errorCount - errorsAtStart);
    endtask

    task automatic clearInputs();
        rsD          = '0;
        rtD          = '0;
        rsE          = '0;
        rtE          = '0;
        destE        = '0;
        destM        = '0;
        destW        = '0;
        writeM       = 1'b0;
        writeW       = 1'b0;
        loadE        = 1'b0;
        mduUseD      = 1'b0;
        likelyD      = 1'b0;
        branchTakenD = 1'b0;
        mduOpE       = MduNone;
    endtask

    // MEM beats WB, register zero is never bypassed
    function automatic fwdSelT expectedFwd(input regAddrT src);
        logic memHit;
        logic wbHit;
        memHit = writeM && (src == destM) && (src != '0);
        wbHit  = writeW && (src == destW) && (src != '0);
        return memHit ? FwdMem : (wbHit ? FwdWb : FwdNone);
    endfunction

    task automatic checkStalls(input logic expStall, input logic expFlushIfId);
        checkValue("stallPc", 32'(expStall), 32'(stallPc));
        checkValue("stallIfId", 32'(expStall), 32'(stallIfId));
        checkValue("flushIdEx", 32'(expStall), 32'(flushIdEx));
        checkValue("flushIfId", 32'(expFlushIfId), 32'(flushIfId));
    endtask

    task automatic checkAllFwd();
        checkValue("fwdAD", 32'(expectedFwd(rsD)), 32'(fwdAD));
        checkValue("fwdBD", 32'(expectedFwd(rtD)), 32'(fwdBD));
        checkValue("fwdAE", 32'(expectedFwd(rsE)), 32'(fwdAE));
        checkValue("fwdBE", 32'(expectedFwd(rtE)), 32'(fwdBE));
    endtask

    task automatic testResetState();
        startTest("reset state");
        @(negedge clk);
        #1;
        checkStalls(1'b0, 1'b0);
        checkValue("mduBusy", 0, 32'(mduBusy));
        checkAllFwd();
        // A reset in the middle of a divide clears the countdown
        @(negedge clk);
        mduOpE = MduDiv;
        @(negedge clk);
        mduOpE = MduNone;
        rstN   = 1'b0;
        @(negedge clk);
        rstN = 1'b1;
        #1;
        checkValue("mduBusy after reset", 0, 32'(mduBusy));
        finishTest();
    endtask

    task automatic testForwarding();
        startTest("forwarding");
        for (int i = 0; i < FwdRounds; i++) begin
            @(negedge clk);
            rsD    = regAddrT'(randomBits(2)); // Few register numbers give many matches
            rtD    = regAddrT'(randomBits(2));
            rsE    = regAddrT'(randomBits(2));
            rtE    = regAddrT'(randomBits(2));
            destM  = regAddrT'(randomBits(2));
            destW  = regAddrT'(randomBits(2));
            writeM = randomBits(1) != 0;
            writeW = randomBits(1) != 0;
            #1;
            checkAllFwd();
        end
        @(negedge clk);
        rsD    = 5'd9;
        rtD    = 5'd0;
        rsE    = 5'd9;
        rtE    = 5'd0;
        destM  = 5'd9;
        destW  = 5'd9;
        writeM = 1'b1;
        writeW = 1'b1;
        #1;
        checkValue("fwdAD both stages", 32'(FwdMem), 32'(fwdAD));
        checkAllFwd();
        // Both stages claim to write register zero
        @(negedge clk);
        destM = 5'd0;
        destW = 5'd0;
        #1;
        checkValue("fwdBE zero register", 32'(FwdNone), 32'(fwdBE));
        checkAllFwd();
        clearInputs();
        finishTest();
    endtask

    task automatic loadCase(input regAddrT rs, input regAddrT rt, input regAddrT dest,
                            input logic load);
        logic expStall;
        @(negedge clk);
        rsD   = rs;
        rtD   = rt;
        destE = dest;
        loadE = load;
        #1;
        expStall = load && (dest != '0) && ((dest == rs) || (dest == rt));
        checkStalls(expStall, 1'b0);
    endtask

    task automatic testLoadUse();
        startTest("load-use");
        loadCase(5'd3, 5'd7, 5'd3, 1'b1);
        loadCase(5'd3, 5'd7, 5'd7, 1'b1);
        loadCase(5'd3, 5'd7, 5'd9, 1'b1);
        loadCase(5'd0, 5'd7, 5'd0, 1'b1);
        loadCase(5'd3, 5'd7, 5'd3, 1'b0);
        for (int i = 0; i < LoadRounds; i++) begin
            loadCase(regAddrT'(randomBits(2)), regAddrT'(randomBits(2)),
                     regAddrT'(randomBits(2)), randomBits(1) != 0);
        end
        clearInputs();
        finishTest();
    endtask

    task automatic busyPeriod(input mduOpT op, input int cycles);
        @(negedge clk);
        mduOpE = op;
        #1;
        checkValue("mduBusy at issue", 0, 32'(mduBusy));
        for (int i = 0; i <= cycles; i++) begin
            @(negedge clk);
            mduOpE = MduNone;
            #1;
            checkValue("mduBusy", 32'(i < cycles), 32'(mduBusy));
        end
    endtask

    task automatic testMduBusy();
        startTest("MDU busy period");
        busyPeriod(MduMult, int'(MultCycles));
        repeat (2) @(negedge clk);
        busyPeriod(MduDiv, int'(DivCycles));
        finishTest();
    endtask

    task automatic testMduStall();
        startTest("MDU stall");
        @(negedge clk);
        mduOpE  = MduMult;
        mduUseD = 1'b0;
        for (int i = 0; i <= int'(MultCycles); i++) begin
            @(negedge clk);
            mduOpE  = MduNone;
            mduUseD = 1'b1; // HI/LO read waiting in decode
            #1;
            checkStalls(i < int'(MultCycles), 1'b0);
        end
        clearInputs();
        finishTest();
    endtask

    task automatic testBranchLikely();
        startTest("branch-likely flush");
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            likelyD      = i[1];
            branchTakenD = i[0];
            #1;
            checkStalls(1'b0, i[1] && !i[0]);
        end
        // A load-use stall in the same cycle holds the unresolved branch
        @(negedge clk);
        likelyD      = 1'b1;
        branchTakenD = 1'b0;
        rsD          = 5'd5;
        destE        = 5'd5;
        loadE        = 1'b1;
        #1;
        checkStalls(1'b1, 1'b0);
        clearInputs();
        finishTest();
    endtask

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired after %0d ns before the tests finished", TimeoutNs);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        lfsrState  = 16'd75;
        checkCount = 0;
        errorCount = 0;
        clearInputs();
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;
        testResetState();
        testForwarding();
        testLoadUse();
        testMduBusy();
        testMduStall();
        testBranchLikely();
        $display("Checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- hazardUnit.f
hazardPkg.sv
regTrackIf.sv
forwardSelect.sv
stallDetect.sv
pipeControl.sv
hazardUnit.sv
hazardUnit_properties.sv
hazardUnitTb.sv

//--- Makefile
# Verilator build and run of the hazard unit testbench

TOP := hazardUnitTb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f hazardUnit.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
